/* entry_pkg.sv */
package entry_pkg;

    // Entry word width, shared by the bus side and the engine
    localparam int ENTRY_W = 32;

    // Sample payload width below the opcode
    localparam int SAMPLE_W = 30;

    // Shift amount field width
    localparam int SHIFT_W = 5;

    // Opcode in bits 31:30 of every entry
    typedef enum logic [1:0] {
        OP_SAMPLE = 2'b00,
        OP_CTRL   = 2'b01,
        OP_RSVD_A = 2'b10,
        OP_RSVD_B = 2'b11
    } entry_op_t;

    // Sample view, value is two's complement over SAMPLE_W bits
    typedef struct packed {
        entry_op_t             op;
        logic [SAMPLE_W-1:0]   value;
    } sample_view_t;

    // Control view, flags and shift amount sit in the low bits
    typedef struct packed {
        entry_op_t                           op;
        logic [ENTRY_W-2-2-SHIFT_W-1:0]      unused;
        logic                                clear;
        logic                                load_shift;
        logic [SHIFT_W-1:0]                  shift_amt;
    } ctrl_view_t;

    // One word, decoded by opcode
    typedef union packed {
        sample_view_t sample;
        ctrl_view_t   ctrl;
    } entry_word_t;

endpackage

/* wb_map_pkg.sv */
package wb_map_pkg;

    // Bus widths, word addressed
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    // Register map
    localparam logic [WB_ADDR_W-1:0] ADDR_ENTRY  = 4'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_ACCUM  = 4'd1;
    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'd2;

    // Status word layout
    localparam int STAT_EMPTY_BIT = 0;
    localparam int STAT_FULL_BIT  = 1;
    localparam int STAT_BUSY_BIT  = 2;
    localparam int STAT_SHIFT_LSB = 3;

    // Shift field occupies bits 7:3
    localparam int STAT_SHIFT_W = 5;

endpackage

/* sync_fifo.sv */
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,

    // Write side
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,

    // Read side
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];

    // Extra MSB tells a wrapped write pointer from an equal one
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    logic do_push;
    logic do_pop;

    // Same index, opposite lap
    assign full  = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]) &&
                   (wr_ptr[PTR_W] != rd_ptr[PTR_W]);
    assign empty = (wr_ptr == rd_ptr);

    // Full and popping frees a slot in the same cycle
    assign do_push = wr_en && (!full || rd_en);
    assign do_pop  = rd_en && !empty;

    // Pointer control
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage and registered read port
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[PTR_W-1:0]] <= din;
        // Holds last popped word between pops
        if (do_pop)
            dout <= mem[rd_ptr[PTR_W-1:0]];
    end

endmodule

/* wb_sample_port.sv */
module wb_sample_port import wb_map_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    // Wishbone classic slave
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADDR_W-1:0]    wb_adr,
    input  logic [WB_DATA_W-1:0]    wb_dat_w,
    output logic [WB_DATA_W-1:0]    wb_dat_r,
    output logic                    wb_ack,

    // FIFO write side
    input  logic                    fifo_full,
    input  logic                    fifo_empty,
    output logic                    fifo_wr_en,
    output logic [WB_DATA_W-1:0]    fifo_din,

    // Engine state for readback
    input  logic [WB_DATA_W-1:0]    accum,
    input  logic [STAT_SHIFT_W-1:0] shift,
    input  logic                    busy
);
    logic                 served;
    logic                 new_req;
    logic                 is_entry;
    logic                 push;
    logic                 accept;
    logic [WB_DATA_W-1:0] status;
    logic [WB_DATA_W-1:0] rd_data;

    // Request not yet answered in this strobe
    assign new_req  = wb_cyc && wb_stb && !served;
    assign is_entry = (wb_adr == ADDR_ENTRY);

    // Entry write waits while the FIFO is full
    assign push   = new_req && wb_we && is_entry && !fifo_full;
    assign accept = new_req && !(wb_we && is_entry && fifo_full);

    // Status word
    always_comb begin
        status = '0;
        status[STAT_EMPTY_BIT] = fifo_empty;
        status[STAT_FULL_BIT]  = fifo_full;
        status[STAT_BUSY_BIT]  = busy;
        status[STAT_SHIFT_LSB +: STAT_SHIFT_W] = shift;
    end

    // Read mux, entry address and holes read as zero
    always_comb begin
        case (wb_adr)
            ADDR_ACCUM:  rd_data = accum;
            ADDR_STATUS: rd_data = status;
            default:     rd_data = '0;
        endcase
    end

    // Ack, push strobe and served flag
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            fifo_wr_en <= 1'b0;
            served     <= 1'b0;
        end else begin
            wb_ack     <= accept;
            fifo_wr_en <= push;
            // Cleared once the master drops stb
            if (accept)
                served <= 1'b1;
            else if (!(wb_cyc && wb_stb))
                served <= 1'b0;
        end
    end

    // Data registers
    always_ff @(posedge clk) begin
        if (push)
            fifo_din <= wb_dat_w;
        if (accept && !wb_we)
            wb_dat_r <= rd_data;
    end

endmodule

/* accum_engine.sv */
module accum_engine import entry_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    // FIFO read side
    input  logic               fifo_empty,
    output logic               fifo_rd_en,
    input  entry_word_t        fifo_dout,

    // Results
    output logic [ENTRY_W-1:0] accum,
    output logic [SHIFT_W-1:0] shift,
    output logic               busy
);
    // High in the apply cycle after a pop
    logic pending;

    logic signed [ENTRY_W-1:0] sample_ext;
    logic signed [ENTRY_W-1:0] sample_shifted;

    // Pop only when nothing waits to be applied
    assign fifo_rd_en = !fifo_empty && !pending;
    assign busy       = !fifo_empty || pending;

    // Sign extend the sample view and scale it down
    always_comb begin
        sample_ext = {{(ENTRY_W-SAMPLE_W){fifo_dout.sample.value[SAMPLE_W-1]}},
                      fifo_dout.sample.value};
        sample_shifted = sample_ext >>> shift;
    end

    // Pop, then apply
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            accum   <= '0;
            shift   <= '0;
        end else if (!pending) begin
            if (fifo_rd_en)
                pending <= 1'b1;
        end else begin
            pending <= 1'b0;
            case (fifo_dout.sample.op)
                OP_SAMPLE: begin
                    // Wraps modulo 2^32
                    accum <= accum + sample_shifted;
                end
                OP_CTRL: begin
                    if (fifo_dout.ctrl.clear)
                        accum <= '0;
                    if (fifo_dout.ctrl.load_shift)
                        shift <= fifo_dout.ctrl.shift_amt;
                end
                // Reserved codes are dropped
                default: ;
            endcase
        end
    end

endmodule

/* accum_top.sv */
module accum_top import entry_pkg::*, wb_map_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,

    // Wishbone classic slave
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [WB_ADDR_W-1:0] wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_w,
    output logic [WB_DATA_W-1:0] wb_dat_r,
    output logic                 wb_ack
);
    // Port to FIFO
    logic               fifo_wr_en;
    logic [ENTRY_W-1:0] fifo_din;
    logic               fifo_full;

    // FIFO to engine
    logic               fifo_rd_en;
    entry_word_t        fifo_dout;
    logic               fifo_empty;

    // Engine state back to the port
    logic [ENTRY_W-1:0] accum;
    logic [SHIFT_W-1:0] shift;
    logic               busy;

    // Producer
    wb_sample_port u_port (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_wr_en (fifo_wr_en),
        .fifo_din   (fifo_din),
        .accum      (accum),
        .shift      (shift),
        .busy       (busy)
    );

    // Entry buffer
    sync_fifo #(
        .WIDTH (ENTRY_W),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (fifo_wr_en),
        .din   (fifo_din),
        .full  (fifo_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    // Consumer
    accum_engine u_engine (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_rd_en (fifo_rd_en),
        .fifo_dout  (fifo_dout),
        .accum      (accum),
        .shift      (shift),
        .busy       (busy)
    );

endmodule

/* fifo_props.sv */
module fifo_props #(
    parameter int PTR_W = 3
) (
    input logic           clk,
    input logic           rst,
    input logic           wr_en,
    input logic           rd_en,
    input logic           full,
    input logic           empty,
    input logic [PTR_W:0] wr_ptr,
    input logic [PTR_W:0] rd_ptr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Push into a full FIFO without a pop is dropped
    push_on_full_dropped: assert property (@(posedge clk) disable iff (rst)
        wr_en && full && !rd_en |=> $stable(wr_ptr))
        else $error("write pointer moved on a push into a full FIFO");

    // Pop from an empty FIFO is ignored
    pop_on_empty_ignored: assert property (@(posedge clk) disable iff (rst)
        rd_en && empty |=> $stable(rd_ptr))
        else $error("read pointer moved on a pop from an empty FIFO");

    // Reset clears both pointers
    reset_state: assert property (@(posedge clk)
        rst |=> (wr_ptr == '0) && (rd_ptr == '0) && !full)
        else $error("FIFO pointers or full flag wrong after reset");

endmodule

bind sync_fifo fifo_props #(.PTR_W(PTR_W)) u_fifo_props (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .full   (full),
    .empty  (empty),
    .wr_ptr (wr_ptr),
    .rd_ptr (rd_ptr)
);

/* accum_tb.sv */
module accum_tb import entry_pkg::*, wb_map_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUS_LIMIT  = 200;
    localparam int POLL_LIMIT = 100;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;

    // Stimulus table with one row per entry word
    entry_word_t stim_word [$];
    logic [31:0] exp_accum [$];
    logic [4:0]  exp_shift [$];
    int          stim_case [$];
    bit          stim_check [$];

    // Reference model state
    logic [31:0] model_acc = '0;
    logic [4:0]  model_shift = '0;

    // Raised by a bus or poll timeout
    bit     hung = 1'b0;
    integer seed = 62;
    int     errors = 0;
    int     cases_ok = 0;
    int     cases_bad = 0;
    string  case_name [1:6] = '{"reset state", "signed sum", "shift by 3",
                                "clear and reserved", "back-pressure", "random mix"};

    accum_top #(.FIFO_DEPTH(8)) DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    // One classic cycle with the request held until ack is seen on a falling edge
    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited == BUS_LIMIT + 1) begin
                $display("ERROR: bus ack never arrived");
                hung = 1'b1;
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        // Strobe low for at least one edge before the next request
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // Poll status until the engine reports idle
    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            wb_read(ADDR_STATUS, status);
            polls++;
            if (polls == POLL_LIMIT + 1) begin
                $display("ERROR: engine stayed busy after the FIFO should have drained");
                hung = 1'b1;
            end
        end while (status[STAT_BUSY_BIT]);
    endtask

    // Idle status is empty set plus the shift in bits 7:3
    task automatic check_drained(input int row);
        logic [31:0] value;
        wait_idle();
        wb_read(ADDR_ACCUM, value);
        check_value("accum", value, exp_accum[row]);
        wb_read(ADDR_STATUS, value);
        check_value("status", value, {24'd0, exp_shift[row], 3'b001});
    endtask

    function automatic entry_word_t sample_word(input int value);
        return {OP_SAMPLE, value[29:0]};
    endfunction

    function automatic entry_word_t ctrl_word(input logic clear, input logic load,
                                              input logic [4:0] amt);
        entry_word_t w;
        w                 = '0;
        w.ctrl.op         = OP_CTRL;
        w.ctrl.clear      = clear;
        w.ctrl.load_shift = load;
        w.ctrl.shift_amt  = amt;
        return w;
    endfunction

    // Append a row and step the model over it
    task automatic add_row(input int case_id, input bit check, input entry_word_t word);
        logic signed [31:0] scaled;
        // Bit 29 moved to the top so one arithmetic shift sign extends and scales
        scaled = $signed({word[29:0], 2'b00}) >>> (model_shift + 2);
        case (word.ctrl.op)
            OP_SAMPLE: model_acc = model_acc + scaled;
            OP_CTRL: begin
                if (word.ctrl.clear)
                    model_acc = '0;
                if (word.ctrl.load_shift)
                    model_shift = word.ctrl.shift_amt;
            end
            default: ;
        endcase
        stim_word.push_back(word);
        exp_accum.push_back(model_acc);
        exp_shift.push_back(model_shift);
        stim_case.push_back(case_id);
        stim_check.push_back(check);
    endtask

    task automatic build_table();
        int sums [6] = '{100, -250, 536870911, -536870912, 7, -1};
        int scale [4] = '{80, -81, 5, -1};
        logic [31:0] r;
        // Extremes of the 30-bit range included
        foreach (sums[k])
            add_row(2, 1'b1, sample_word(sums[k]));
        add_row(3, 1'b1, ctrl_word(1'b0, 1'b1, 5'd3));
        foreach (scale[k])
            add_row(3, 1'b1, sample_word(scale[k]));
        // Clear alone then clear with shift 1 then both reserved codes
        add_row(4, 1'b1, ctrl_word(1'b1, 1'b0, 5'd0));
        add_row(4, 1'b1, sample_word(64));
        add_row(4, 1'b1, ctrl_word(1'b1, 1'b1, 5'd1));
        add_row(4, 1'b1, sample_word(10));
        add_row(4, 1'b1, {OP_RSVD_A, 30'h3fff_ffff});
        add_row(4, 1'b1, {OP_RSVD_B, 30'h0000_0155});
        // Back to back writes checked once at the end
        for (int k = 0; k < 20; k++)
            add_row(5, k == 19, sample_word(k * 1237 - 9000));
        // About one in four is a control word
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            if (r[31:30] == 2'b11)
                add_row(6, k % 8 == 7, ctrl_word(r[6], r[5], r[4:0]));
            else
                add_row(6, k % 8 == 7, sample_word(r));
        end
    endtask

    task automatic report_case(input int id, input int errors_before);
        if (errors == errors_before) begin
            cases_ok++;
            $display("case %0d (%s): ok", id, case_name[id]);
        end else begin
            cases_bad++;
            $display("case %0d (%s): %0d mismatches", id, case_name[id],
                     errors - errors_before);
        end
    endtask

    // Budget scales with the table length built at time zero
    initial begin
        int budget;
        #1;
        budget = stim_word.size() * 40 + 2000;
        while (!hung && budget > 0) begin
            @(posedge clk);
            budget--;
        end
        if (!hung)
            $display("ERROR: watchdog expired before the table was applied");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] value;
        int mark;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Only empty is set in status after reset
        mark = errors;
        wb_read(ADDR_STATUS, value);
        check_value("status", value, 32'h0000_0001);
        wb_read(ADDR_ACCUM, value);
        check_value("accum", value, 32'h0);
        report_case(1, mark);

        // Table cases in order
        for (int c = 2; c <= 6; c++) begin
            mark = errors;
            foreach (stim_word[i]) begin
                if (stim_case[i] == c) begin
                    wb_write(ADDR_ENTRY, stim_word[i]);
                    if (stim_check[i])
                        check_drained(i);
                end
            end
            report_case(c, mark);
        end

        $display("cases ok: %0d, cases with errors: %0d", cases_ok, cases_bad);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* flist.f */
entry_pkg.sv
wb_map_pkg.sv
sync_fifo.sv
wb_sample_port.sv
accum_engine.sv
accum_top.sv
fifo_props.sv
accum_tb.sv

/* Bender.yml */
package:
  name: accum_fifo

sources:
  - entry_pkg.sv
  - wb_map_pkg.sv
  - sync_fifo.sv
  - wb_sample_port.sv
  - accum_engine.sv
  - accum_top.sv
  - target: test
    files:
      - fifo_props.sv
      - accum_tb.sv
